// ==== hw/bht_pkg.sv ====
//**************************************************************************
// branch history table package
// sizes, two-bit counter encodings and the shared pc, request, response,
// route and prediction types of the banked BHT
//**************************************************************************
package bht_pkg;

    localparam int BANKS     = 4;
    localparam int BANK_BITS = 2;
    localparam int ENTRIES   = 64;   // counters per bank
    localparam int IDX_BITS  = 6;
    localparam int CTR_BITS  = 2;

    // saturating counter states, upper bit is the direction
    localparam logic [CTR_BITS-1:0] CTR_SN = 2'b00;
    localparam logic [CTR_BITS-1:0] CTR_WN = 2'b01;
    localparam logic [CTR_BITS-1:0] CTR_WT = 2'b10;
    localparam logic [CTR_BITS-1:0] CTR_ST = 2'b11;

    // pc word, raw or split into table fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [31-IDX_BITS-BANK_BITS-2:0] tag;     // not compared
            logic [IDX_BITS-1:0]              index;   // pc[9:4]
            logic [BANK_BITS-1:0]             bank;    // pc[3:2]
            logic [1:0]                       offset;
        } f;
    } pc_u;

    typedef struct packed {
        logic                lookup_en;
        logic [IDX_BITS-1:0] lookup_idx;
        logic                update_en;
        logic [IDX_BITS-1:0] update_idx;
        logic                update_taken;
    } bank_req_t;

    typedef struct packed {
        logic [CTR_BITS-1:0] lookup_ctr;
        logic                lookup_known;
        logic                update_dir;    // direction before the update
    } bank_rsp_t;

    typedef struct packed {
        logic                 lookup_v;
        logic [BANK_BITS-1:0] lookup_bank;
        logic                 update_v;
        logic [BANK_BITS-1:0] update_bank;
        logic                 update_taken;
    } route_t;

    typedef struct packed {
        logic                taken;
        logic [CTR_BITS-1:0] ctr;
        logic                known;
    } pred_t;

endpackage

// ==== hw/bht_router.sv ====
//**************************************************************************
// BHT request router
// turns the fetch and resolve pcs into one-hot bank requests and
// registers which bank answers in the following cycle
//**************************************************************************
`timescale 1ns/1ps

module bht_router (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_valid,
    input  bht_pkg::pc_u       fetch_pc,
    input  logic               resolve_valid,
    input  bht_pkg::pc_u       resolve_pc,
    input  logic               resolve_taken,
    output bht_pkg::bank_req_t req [bht_pkg::BANKS],
    output bht_pkg::route_t    route
);

    logic [bht_pkg::BANKS-1:0] look_hot;   // one bank per strobe
    logic [bht_pkg::BANKS-1:0] upd_hot;

    always_comb begin
        look_hot = '0;
        upd_hot  = '0;
        if (fetch_valid) begin
            look_hot[fetch_pc.f.bank] = 1'b1;
        end
        if (resolve_valid) begin
            upd_hot[resolve_pc.f.bank] = 1'b1;
        end
    end

    // index and outcome go to every bank, only the enable is steered
    always_comb begin
        for (int b = 0; b < bht_pkg::BANKS; b++) begin
            req[b].lookup_en    = look_hot[b];
            req[b].lookup_idx   = fetch_pc.f.index;
            req[b].update_en    = upd_hot[b];
            req[b].update_idx   = resolve_pc.f.index;
            req[b].update_taken = resolve_taken;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            route <= '0;
        end else begin
            route.lookup_v     <= fetch_valid;
            route.lookup_bank  <= fetch_pc.f.bank;
            route.update_v     <= resolve_valid;
            route.update_bank  <= resolve_pc.f.bank;
            route.update_taken <= resolve_taken;   // compared against update_dir
        end
    end

    a_one_hot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(look_hot) && $onehot0(upd_hot))
        else $error("more than one bank enabled in a cycle");

endmodule

// ==== hw/bht_bank.sv ====
//**************************************************************************
// BHT bank
// 64 two-bit saturating counters with trained flags, a registered lookup
// read and a one-step update per cycle
//**************************************************************************
`timescale 1ns/1ps

module bht_bank (
    input  logic               clk,
    input  logic               rst,
    input  bht_pkg::bank_req_t req,
    output bht_pkg::bank_rsp_t rsp
);

    logic [bht_pkg::CTR_BITS-1:0] ctr_q   [bht_pkg::ENTRIES];
    logic                         known_q [bht_pkg::ENTRIES];   // ever trained
    logic [bht_pkg::CTR_BITS-1:0] upd_old;
    logic [bht_pkg::CTR_BITS-1:0] upd_new;

    assign upd_old = ctr_q[req.update_idx];

    // one step toward the outcome, held at either end
    always_comb begin
        case (upd_old)
            bht_pkg::CTR_SN: begin
                upd_new = req.update_taken ? bht_pkg::CTR_WN : bht_pkg::CTR_SN;
            end
            bht_pkg::CTR_WN: begin
                upd_new = req.update_taken ? bht_pkg::CTR_WT : bht_pkg::CTR_SN;
            end
            bht_pkg::CTR_WT: begin
                upd_new = req.update_taken ? bht_pkg::CTR_ST : bht_pkg::CTR_WN;
            end
            bht_pkg::CTR_ST: begin
                upd_new = req.update_taken ? bht_pkg::CTR_ST : bht_pkg::CTR_WT;
            end
            default: begin
                upd_new = upd_old;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bht_pkg::ENTRIES; i++) begin
                ctr_q[i]   <= bht_pkg::CTR_SN;
                known_q[i] <= 1'b0;
            end
        end else if (req.update_en) begin
            ctr_q[req.update_idx]   <= upd_new;
            known_q[req.update_idx] <= 1'b1;
        end
    end

    // reads sample the arrays before this edge's write lands
    always_ff @(posedge clk) begin
        if (req.lookup_en) begin
            rsp.lookup_ctr   <= ctr_q[req.lookup_idx];
            rsp.lookup_known <= known_q[req.lookup_idx];
        end
        if (req.update_en) begin
            rsp.update_dir <= upd_old[bht_pkg::CTR_BITS-1];
        end
    end

    a_one_step: assert property (@(posedge clk) disable iff (rst)
        req.update_en |=>
            (int'(ctr_q[$past(req.update_idx)]) - int'($past(upd_old))) inside {-1, 0, 1})
        else $error("counter moved more than one step on an update");

endmodule

// ==== hw/bht_merge.sv ====
//**************************************************************************
// BHT merge stage
// picks the answering bank's response, forms the prediction and flags
// a mispredict from the pre-update direction bit
//**************************************************************************
`timescale 1ns/1ps

module bht_merge (
    input  logic               clk,
    input  logic               rst,
    input  bht_pkg::route_t    route,
    input  bht_pkg::bank_rsp_t rsp [bht_pkg::BANKS],
    output logic               pred_valid,
    output bht_pkg::pred_t     pred,
    output logic               mispredict
);

    bht_pkg::bank_rsp_t look_rsp;   // bank that served last cycle's fetch
    bht_pkg::bank_rsp_t upd_rsp;    // bank that took last cycle's resolve

    assign look_rsp = rsp[route.lookup_bank];
    assign upd_rsp  = rsp[route.update_bank];

    assign pred_valid = route.lookup_v;

    always_comb begin
        pred.taken = look_rsp.lookup_ctr[bht_pkg::CTR_BITS-1];   // direction bit
        pred.ctr   = look_rsp.lookup_ctr;
        pred.known = look_rsp.lookup_known;
    end

    // wrong when the old direction disagrees with the resolved outcome
    assign mispredict = route.update_v && (upd_rsp.update_dir != route.update_taken);

    a_misp_needs_update: assert property (@(posedge clk) disable iff (rst)
        mispredict |-> route.update_v)
        else $error("mispredict without a registered update");

    // an untrained entry has never left strongly not-taken
    a_unknown_is_sn: assert property (@(posedge clk) disable iff (rst)
        pred_valid && !pred.known |-> pred.ctr == bht_pkg::CTR_SN)
        else $error("untrained entry returned a moved counter");

endmodule

// ==== hw/branch_history_table.sv ====
//**************************************************************************
// banked branch history table
// 256 two-bit counters in four banks, fetch lookup and resolve update,
// prediction and mispredict one cycle later
//**************************************************************************
`timescale 1ns/1ps

module branch_history_table (
    input  logic           clk,
    input  logic           rst,
    input  logic           fetch_valid,
    input  bht_pkg::pc_u   fetch_pc,
    input  logic           resolve_valid,
    input  bht_pkg::pc_u   resolve_pc,
    input  logic           resolve_taken,
    output logic           pred_valid,
    output bht_pkg::pred_t pred,
    output logic           mispredict
);

    bht_pkg::bank_req_t req [bht_pkg::BANKS];   // one-hot enables
    bht_pkg::bank_rsp_t rsp [bht_pkg::BANKS];
    bht_pkg::route_t    route;                   // who answers in k+1

    bht_router u_router (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .resolve_valid (resolve_valid),
        .resolve_pc    (resolve_pc),
        .resolve_taken (resolve_taken),
        .req           (req),
        .route         (route)
    );

    genvar b;
    generate
        for (b = 0; b < bht_pkg::BANKS; b++) begin : g_bank
            bht_bank u_bank (
                .clk (clk),
                .rst (rst),
                .req (req[b]),
                .rsp (rsp[b])
            );
        end
    endgenerate

    bht_merge u_merge (
        .clk        (clk),
        .rst        (rst),
        .route      (route),
        .rsp        (rsp),
        .pred_valid (pred_valid),
        .pred       (pred),
        .mispredict (mispredict)
    );

endmodule

// ==== include/bht_model.svh ====
//**************************************************************************
// BHT reference model
// 4 x 64 two-bit saturating counters with trained flags, used by the
// testbench to predict lookups and mispredicts
//**************************************************************************
`ifndef BHT_MODEL_SVH
`define BHT_MODEL_SVH

logic [1:0] ref_ctr   [4][64];
logic       ref_known [4][64];   // set by the first update

task automatic clear_table();
    for (int b = 0; b < 4; b++) begin
        for (int i = 0; i < 64; i++) begin
            ref_ctr[b][i]   = 2'b00;
            ref_known[b][i] = 1'b0;
        end
    end
endtask

// lookup result as the DUT should show it one cycle later
task automatic read_entry(input logic [31:0] pc, output bht_pkg::pred_t p);
    logic [1:0] bank;
    logic [5:0] idx;
    bank    = pc[3:2];
    idx     = pc[9:4];
    p.ctr   = ref_ctr[bank][idx];
    p.taken = p.ctr[1];                          // upper bit is direction
    p.known = ref_known[bank][idx];
endtask

// one step toward the outcome, returns the direction held before
task automatic train_entry(input logic [31:0] pc, input logic taken, output logic old_dir);
    logic [1:0] bank;
    logic [5:0] idx;
    logic [1:0] c;
    bank    = pc[3:2];
    idx     = pc[9:4];
    c       = ref_ctr[bank][idx];
    old_dir = c[1];
    if (taken && c != 2'b11) begin
        c = c + 2'd1;
    end else if (!taken && c != 2'b00) begin
        c = c - 2'd1;
    end
    ref_ctr[bank][idx]   = c;
    ref_known[bank][idx] = 1'b1;
endtask

`endif

// ==== bench/tb_branch_history_table.sv ====
//**************************************************************************
// testbench for the banked branch history table
// directed and random fetch and resolve traffic checked against a model
//**************************************************************************
`timescale 1ns/1ps

module tb_branch_history_table;

    localparam int RUN_CYCLES = 8 + 33 + 12 + 13 + 4 + 2001;   // reset plus all tests
    localparam int MARGIN     = 200;

    typedef struct packed {
        logic           pv;
        bht_pkg::pred_t p;
        logic           misp;
    } expect_t;

    logic           clk = 1'b0;
    logic           rst;
    logic           fetch_valid;
    bht_pkg::pc_u   fetch_pc;
    logic           resolve_valid;
    bht_pkg::pc_u   resolve_pc;
    logic           resolve_taken;
    logic           pred_valid;
    bht_pkg::pred_t pred;
    logic           mispredict;

    expect_t exp_q [$];   // one entry per driven cycle
    string   cur_test;
    int      test_errs;
    int      total_errs;
    int      tests_run;
    int      tests_failed;
    int      checks;

    `include "bht_model.svh"

    branch_history_table dut (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .resolve_valid (resolve_valid),
        .resolve_pc    (resolve_pc),
        .resolve_taken (resolve_taken),
        .pred_valid    (pred_valid),
        .pred          (pred),
        .mispredict    (mispredict)
    );

    always #50 clk = ~clk;

    // outputs now reflect the previous cycle's strobes
    task automatic check_outputs();
        expect_t e;
        e = '0;
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
        end
        checks++;
        if (pred_valid !== e.pv) begin
            if (e.pv) begin
                $display("%s: a fetch got no prediction, pred_valid stayed low", cur_test);
            end else begin
                $display("%s: pred_valid came high without a fetch", cur_test);
            end
            test_errs++;
        end else if (e.pv && pred !== e.p) begin
            $display("[FAIL] %s pred expected %b_%b_%b actual %b_%b_%b", cur_test,
                     e.p.taken, e.p.ctr, e.p.known, pred.taken, pred.ctr, pred.known);
            test_errs++;
        end
        if (mispredict !== e.misp) begin
            if (e.misp) begin
                $display("%s: mispredict pulse missing", cur_test);
            end else begin
                $display("%s: unexpected mispredict pulse", cur_test);
            end
            test_errs++;
        end
    endtask

    // entered 5 ns after a rising edge, leaves 5 ns after the next one
    task automatic run_cycle(input logic fv, input logic [31:0] fpc,
                             input logic rv, input logic [31:0] rpc, input logic rt);
        expect_t        e;
        bht_pkg::pred_t p;
        logic           old_dir;
        check_outputs();
        fetch_valid    = fv;
        fetch_pc.raw   = fpc;
        resolve_valid  = rv;
        resolve_pc.raw = rpc;
        resolve_taken  = rt;
        e = '0;
        if (fv) begin   // read first, so a same-entry update is not seen
            read_entry(fpc, p);
            e.pv = 1'b1;
            e.p  = p;
        end
        if (rv) begin
            train_entry(rpc, rt, old_dir);
            e.misp = (old_dir != rt);
        end
        exp_q.push_back(e);
        @(posedge clk);
        #5;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs != 0) begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, test_errs);
        end else begin
            $display("test %s: ok", cur_test);
        end
    endtask

    task automatic reset_lookups();
        start_test("reset_state");
        repeat (32) run_cycle(1'b1, $urandom, 1'b0, 32'h0, 1'b0);
        run_cycle(1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
        finish_test();
    endtask

    task automatic saturate_counter();
        logic [31:0] pc;
        start_test("saturation");
        pc = 32'h0000_0154;   // bank 1, index 0x15
        for (int i = 0; i < 10; i++) begin
            run_cycle(1'b1, pc, 1'b1, pc, i < 5);
        end
        run_cycle(1'b1, pc, 1'b0, 32'h0, 1'b0);
        run_cycle(1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
        finish_test();
    endtask

    task automatic train_banks_apart();
        logic [31:0] pcs [4];
        start_test("bank_independence");
        for (int b = 0; b < 4; b++) begin
            pcs[b] = {22'h0, 6'h2a, 2'(b), 2'b00};
        end
        repeat (3) run_cycle(1'b0, 32'h0, 1'b1, pcs[1], 1'b1);
        repeat (2) run_cycle(1'b0, 32'h0, 1'b1, pcs[2], 1'b0);
        run_cycle(1'b0, 32'h0, 1'b1, pcs[3], 1'b1);
        for (int b = 0; b < 4; b++) begin
            run_cycle(1'b1, pcs[b], 1'b0, 32'h0, 1'b0);
        end
        run_cycle(1'b1, {22'h0, 6'h2b, 2'd1, 2'b00}, 1'b0, 32'h0, 1'b0);   // neighbours
        run_cycle(1'b1, {22'h0, 6'h29, 2'd3, 2'b00}, 1'b0, 32'h0, 1'b0);
        run_cycle(1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
        finish_test();
    endtask

    task automatic collide_same_pc();
        logic [31:0] pc;
        start_test("same_cycle_collision");
        pc = 32'h0000_03a8;
        run_cycle(1'b1, pc, 1'b1, pc, 1'b1);
        run_cycle(1'b1, pc, 1'b1, pc, 1'b1);
        run_cycle(1'b1, pc, 1'b0, 32'h0, 1'b0);
        run_cycle(1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
        finish_test();
    endtask

    task automatic random_traffic();
        logic [31:0] pool [8];
        start_test("random_mix");
        for (int i = 0; i < 8; i++) begin   // few indices so entries get reused
            pool[i] = {22'($urandom), 6'($urandom % 3), 2'($urandom), 2'b00};
        end
        repeat (2000) begin
            run_cycle(($urandom % 4) != 0, pool[3'($urandom)],
                      ($urandom % 3) != 0, pool[3'($urandom)], 1'($urandom));
        end
        run_cycle(1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
        finish_test();
    endtask

    initial begin
        void'($urandom(32'hb3dd));
        rst           = 1'b1;
        fetch_valid   = 1'b0;
        fetch_pc      = '0;
        resolve_valid = 1'b0;
        resolve_pc    = '0;
        resolve_taken = 1'b0;
        total_errs    = 0;
        tests_run     = 0;
        tests_failed  = 0;
        checks        = 0;
        clear_table();
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;
        reset_lookups();
        saturate_counter();
        train_banks_apart();
        collide_same_pc();
        random_traffic();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errs);
        if (total_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((RUN_CYCLES + MARGIN) * 100);
        $display("watchdog expired, the run did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
hw/bht_pkg.sv
hw/bht_router.sv
hw/bht_bank.sv
hw/bht_merge.sv
hw/branch_history_table.sv
bench/tb_branch_history_table.sv

// ==== Makefile ====
TOP = tb_branch_history_table
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
